// File: Bender.yml
package:
  name: rv32i_pipeline

sources:
  - rtl/cpu_pkg.sv
  - rtl/hazard_if.sv
  - rtl/imm_gen.sv
  - rtl/control_unit.sv
  - rtl/alu.sv
  - rtl/reg_file.sv
  - rtl/hazard_unit.sv
  - rtl/cpu.sv
  - target: test
    files:
      - test/cpu_assertions.sv
      - test/tb_cpu.sv

// File: rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import cpu_pkg::*; (
	input alu_op_e op,
	input word_t a,
	input word_t b,
	output word_t result
);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_sll: result = a << b[4:0];
			alu_slt: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: result = {{(XLEN-1){1'b0}}, a < b};
			alu_xor: result = a ^ b;
			alu_srl: result = a >> b[4:0];
			alu_sra: result = word_t'($signed(a) >>> b[4:0]);
			alu_or: result = a | b;
			alu_and: result = a & b;
			// lui
			alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit import cpu_pkg::*; (
	input word_t instr,
	output ctrl_t ctrl,
	output logic illegal
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic alt;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign alt = instr[30];

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000: return sub_sra ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return sub_sra ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		// All zero is an add with no side effects
		ctrl = '0;
		illegal = 1'b0;
		case (opcode)
			opc_op: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_op = arith_op(funct3, alt);
			end
			opc_op_imm: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				// Only srai uses the funct7 bit, addi never subtracts
				ctrl.alu_op = arith_op(funct3, alt && funct3 == 3'b101);
			end
			opc_load: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				illegal = funct3 != 3'b010;
			end
			opc_store: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				illegal = funct3 != 3'b010;
			end
			opc_branch: begin
				ctrl.branch = 1'b1;
				illegal = funct3[2:1] == 2'b01;
			end
			opc_jal: begin
				ctrl.jump = 1'b1;
				ctrl.write_reg = 1'b1;
				ctrl.pc_to_reg = 1'b1;
			end
			opc_jalr: begin
				ctrl.jump = 1'b1;
				ctrl.jalr = 1'b1;
				ctrl.write_reg = 1'b1;
				ctrl.pc_to_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			opc_lui: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = alu_pass_b;
			end
			opc_auipc: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_a_pc = 1'b1;
			end
			default:
				illegal = 1'b1;
		endcase
		// Canonical nop needs no write-back
		if (instr == NOP_INSTR)
			ctrl.write_reg = 1'b0;
		if (illegal)
			ctrl = '0;
	end

endmodule

`default_nettype wire

// File: rtl/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output word_t addr,
	input word_t i_mem_out,
	output word_t d_addr,
	output word_t data_mem_in,
	input word_t data_mem_out,
	output logic data_mem_write_enable,
	output logic data_mem_read_enable
);

	hazard_if hz ();

	word_t pc, pc_next;
	logic if_id_valid;
	word_t if_id_instr, if_id_pc;
	ctrl_t id_ctrl;
	logic id_illegal;
	word_t id_imm, id_rs1_data, id_rs2_data;
	logic id_ex_valid;
	ctrl_t id_ex_ctrl;
	branch_cond_e id_ex_cond;
	word_t id_ex_pc, id_ex_imm, id_ex_rs1_data, id_ex_rs2_data;
	reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;
	word_t ex_op_a, ex_op_b, alu_a, alu_b, alu_result, ex_target;
	logic cond_true, take_branch;
	logic ex_mem_valid;
	ctrl_t ex_mem_ctrl;
	word_t ex_mem_pc, ex_mem_alu, ex_mem_store, mem_result;
	reg_addr_t ex_mem_rd;
	logic mem_wb_valid, wb_write;
	ctrl_t mem_wb_ctrl;
	word_t mem_wb_pc, mem_wb_alu, mem_wb_load, wb_result;
	reg_addr_t mem_wb_rd;

	function automatic word_t select_result(input ctrl_t c, input word_t pc_val,
		input word_t load_val, input word_t alu_val);
		if (c.pc_to_reg)
			return pc_val + 32'd4;
		if (c.mem_read)
			return load_val;
		return alu_val;
	endfunction

	function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
		input word_t mem_val, input word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// Fetch
	assign addr = pc;
	assign pc_next = take_branch ? ex_target : hz.stall ? pc : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (reset || hz.flush)
			if_id_valid <= 1'b0;
		else if (!hz.stall)
			if_id_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!hz.stall) begin
			if_id_instr <= i_mem_out;
			if_id_pc <= pc;
		end
	end

	// Decode
	assign hz.id_rs1 = if_id_instr[19:15];
	assign hz.id_rs2 = if_id_instr[24:20];

	imm_gen u_imm_gen (.instr(if_id_instr), .imm(id_imm));
	control_unit u_control_unit (.instr(if_id_instr), .ctrl(id_ctrl), .illegal(id_illegal));

	reg_file #(.DATA_W(XLEN), .ADDR_W(REG_ADDR_W)) u_reg_file (
		.clk(clk),
		.rs1(hz.id_rs1),
		.rs2(hz.id_rs2),
		.rd(mem_wb_rd),
		.rd_data(wb_result),
		.write_enable(wb_write),
		.rs1_data(id_rs1_data),
		.rs2_data(id_rs2_data)
	);

	// Stall leaves a bubble behind the held instruction
	always_ff @(posedge clk) begin
		if (reset || hz.flush || hz.stall)
			id_ex_valid <= 1'b0;
		else
			id_ex_valid <= if_id_valid && !id_illegal;
	end

	always_ff @(posedge clk) begin
		id_ex_ctrl <= id_ctrl;
		id_ex_cond <= branch_cond_e'(if_id_instr[14:12]);
		id_ex_pc <= if_id_pc;
		id_ex_imm <= id_imm;
		id_ex_rs1_data <= id_rs1_data;
		id_ex_rs2_data <= id_rs2_data;
		id_ex_rs1 <= hz.id_rs1;
		id_ex_rs2 <= hz.id_rs2;
		id_ex_rd <= if_id_instr[11:7];
	end

	// Execute
	assign ex_op_a = fwd_mux(hz.fwd_a, id_ex_rs1_data, mem_result, wb_result);
	assign ex_op_b = fwd_mux(hz.fwd_b, id_ex_rs2_data, mem_result, wb_result);
	assign alu_a = id_ex_ctrl.alu_a_pc ? id_ex_pc : ex_op_a;
	assign alu_b = id_ex_ctrl.alu_src_imm ? id_ex_imm : ex_op_b;

	alu u_alu (.op(id_ex_ctrl.alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

	always_comb begin
		case (id_ex_cond)
			br_beq: cond_true = ex_op_a == ex_op_b;
			br_bne: cond_true = ex_op_a != ex_op_b;
			br_blt: cond_true = $signed(ex_op_a) < $signed(ex_op_b);
			br_bge: cond_true = $signed(ex_op_a) >= $signed(ex_op_b);
			br_bltu: cond_true = ex_op_a < ex_op_b;
			br_bgeu: cond_true = ex_op_a >= ex_op_b;
			default: cond_true = 1'b0;
		endcase
	end

	assign take_branch = id_ex_valid && (id_ex_ctrl.jump || (id_ex_ctrl.branch && cond_true));
	// Bit 0 cleared for jalr
	assign ex_target = ((id_ex_ctrl.jalr ? ex_op_a : id_ex_pc) + id_ex_imm) & ~word_t'(1);

	assign hz.ex_rs1 = id_ex_rs1;
	assign hz.ex_rs2 = id_ex_rs2;
	assign hz.ex_rd = id_ex_rd;
	assign hz.ex_write_reg = id_ex_valid && id_ex_ctrl.write_reg;
	assign hz.ex_mem_read = id_ex_valid && id_ex_ctrl.mem_read;
	assign hz.take_branch = take_branch;

	hazard_unit u_hazard_unit (.hz(hz));

	always_ff @(posedge clk) begin
		if (reset)
			ex_mem_valid <= 1'b0;
		else
			ex_mem_valid <= id_ex_valid;
	end

	always_ff @(posedge clk) begin
		ex_mem_ctrl <= id_ex_ctrl;
		ex_mem_pc <= id_ex_pc;
		ex_mem_alu <= alu_result;
		ex_mem_store <= ex_op_b;
		ex_mem_rd <= id_ex_rd;
	end

	// Memory
	assign d_addr = ex_mem_alu;
	assign data_mem_in = ex_mem_store;
	assign data_mem_write_enable = ex_mem_valid && ex_mem_ctrl.mem_write;
	assign data_mem_read_enable = ex_mem_valid && ex_mem_ctrl.mem_read;
	// The load-use stall keeps load data out of this path
	assign mem_result = ex_mem_ctrl.pc_to_reg ? ex_mem_pc + 32'd4 : ex_mem_alu;

	assign hz.mem_rd = ex_mem_rd;
	assign hz.mem_write_reg = ex_mem_valid && ex_mem_ctrl.write_reg;

	always_ff @(posedge clk) begin
		if (reset)
			mem_wb_valid <= 1'b0;
		else
			mem_wb_valid <= ex_mem_valid;
	end

	always_ff @(posedge clk) begin
		mem_wb_ctrl <= ex_mem_ctrl;
		mem_wb_pc <= ex_mem_pc;
		mem_wb_alu <= ex_mem_alu;
		mem_wb_load <= data_mem_out;
		mem_wb_rd <= ex_mem_rd;
	end

	// Write-back
	assign wb_result = select_result(mem_wb_ctrl, mem_wb_pc, mem_wb_load, mem_wb_alu);
	assign wb_write = mem_wb_valid && mem_wb_ctrl.write_reg;
	assign hz.wb_rd = mem_wb_rd;
	assign hz.wb_write_reg = wb_write;

endmodule

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	parameter int XLEN = 32;
	parameter int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [6:0] {
		opc_op = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_load = 7'b0000011,
		opc_store = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal = 7'b1101111,
		opc_jalr = 7'b1100111,
		opc_lui = 7'b0110111,
		opc_auipc = 7'b0010111
	} opcode_e;

	// Low bits follow funct3, bit 3 follows funct7[5]
	typedef enum logic [3:0] {
		alu_add = 4'b0000,
		alu_sub = 4'b1000,
		alu_sll = 4'b0001,
		alu_slt = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor = 4'b0100,
		alu_srl = 4'b0101,
		alu_sra = 4'b1101,
		alu_or = 4'b0110,
		alu_and = 4'b0111,
		alu_pass_b = 4'b1111
	} alu_op_e;

	typedef enum logic [2:0] {
		br_beq = 3'b000,
		br_bne = 3'b001,
		br_blt = 3'b100,
		br_bge = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} branch_cond_e;

	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic alu_src_imm;
		logic alu_a_pc;
		logic branch;
		logic jump;
		logic jalr;
		logic write_reg;
		logic mem_read;
		logic mem_write;
		logic pc_to_reg;
	} ctrl_t;

	// addi x0, x0, 0
	parameter word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: rtl/hazard_if.sv
`timescale 1ns/100ps
`default_nettype none

interface hazard_if import cpu_pkg::*; ();
	reg_addr_t id_rs1, id_rs2;
	reg_addr_t ex_rs1, ex_rs2, ex_rd;
	logic ex_write_reg, ex_mem_read;
	reg_addr_t mem_rd;
	logic mem_write_reg;
	reg_addr_t wb_rd;
	logic wb_write_reg;
	logic take_branch;
	fwd_sel_e fwd_a, fwd_b;
	logic stall, flush;

	modport pipeline (
		output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_write_reg, ex_mem_read,
		output mem_rd, mem_write_reg, wb_rd, wb_write_reg, take_branch,
		input fwd_a, fwd_b, stall, flush
	);

	modport hazard (
		input id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_write_reg, ex_mem_read,
		input mem_rd, mem_write_reg, wb_rd, wb_write_reg, take_branch,
		output fwd_a, fwd_b, stall, flush
	);
endinterface

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
	hazard_if.hazard hz
);

	// Memory stage is younger, so it wins over write-back
	function automatic fwd_sel_e fwd_pick(
		input reg_addr_t src,
		input logic mem_wr,
		input reg_addr_t mem_rd,
		input logic wb_wr,
		input reg_addr_t wb_rd
	);
		if (src == '0)
			return fwd_reg;
		if (mem_wr && mem_rd == src)
			return fwd_mem;
		if (wb_wr && wb_rd == src)
			return fwd_wb;
		return fwd_reg;
	endfunction

	assign hz.fwd_a = fwd_pick(hz.ex_rs1, hz.mem_write_reg, hz.mem_rd,
		hz.wb_write_reg, hz.wb_rd);
	assign hz.fwd_b = fwd_pick(hz.ex_rs2, hz.mem_write_reg, hz.mem_rd,
		hz.wb_write_reg, hz.wb_rd);

	// Load result only exists once the load reaches the memory stage
	assign hz.stall = hz.ex_mem_read && hz.ex_write_reg && hz.ex_rd != '0
		&& (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

	assign hz.flush = hz.take_branch;

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen import cpu_pkg::*; (
	input word_t instr,
	output word_t imm
);

	always_comb begin
		case (opcode_e'(instr[6:0]))
			// I format
			opc_op_imm, opc_load, opc_jalr:
				imm = {{20{instr[31]}}, instr[31:20]};
			opc_store:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			opc_branch:
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			opc_lui, opc_auipc:
				imm = {instr[31:12], 12'b0};
			opc_jal:
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			// R format and anything unknown
			default:
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
	parameter int DATA_W = 32,
	parameter int ADDR_W = 5
) (
	input logic clk,
	input logic [ADDR_W-1:0] rs1,
	input logic [ADDR_W-1:0] rs2,
	input logic [ADDR_W-1:0] rd,
	input logic [DATA_W-1:0] rd_data,
	input logic write_enable,
	output logic [DATA_W-1:0] rs1_data,
	output logic [DATA_W-1:0] rs2_data
);

	logic [DATA_W-1:0] regs [2**ADDR_W];

	// x0 reads zero, a same-cycle write is passed through
	function automatic logic [DATA_W-1:0] read_port(input logic [ADDR_W-1:0] idx);
		if (idx == '0)
			return '0;
		if (write_enable && idx == rd)
			return rd_data;
		return regs[idx];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	always_ff @(posedge clk) begin
		if (write_enable && rd != '0)
			regs[rd] <= rd_data;
	end

endmodule

`default_nettype wire

// File: src.f
rtl/cpu_pkg.sv
rtl/hazard_if.sv
rtl/imm_gen.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/cpu.sv
test/cpu_assertions.sv
test/tb_cpu.sv

// File: test/cpu_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t d_addr,
	input logic data_mem_write_enable,
	input logic data_mem_read_enable
);

	int error_count = 0;
	logic reset_q;

	// Reset seen at the previous edge
	always @(posedge clk)
		reset_q <= reset;

	// Covers each reset cycle and the first cycle after it
	reset_quiet: assert property (@(posedge clk)
		reset_q |-> !data_mem_write_enable && !data_mem_read_enable)
		else begin
			error_count++;
			$error("data enable high during or right after reset");
		end

	no_read_write: assert property (@(posedge clk) disable iff (reset)
		!(data_mem_write_enable && data_mem_read_enable))
		else begin
			error_count++;
			$error("data read and write enables high together");
		end

	word_aligned: assert property (@(posedge clk) disable iff (reset)
		(data_mem_write_enable || data_mem_read_enable) |-> d_addr[1:0] == 2'b00)
		else begin
			error_count++;
			$error("data access to unaligned address %h", d_addr);
		end

endmodule

`default_nettype wire

// File: test/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam int store_timeout = 100;

	logic clk;
	logic reset;
	word_t addr, i_mem_out, d_addr, data_mem_in, data_mem_out;
	logic data_mem_write_enable, data_mem_read_enable;

	word_t rom [256];
	word_t dmem [256];
	word_t dmem_init [256];
	int prog_len;
	integer seed;
	word_t exp_addr [$];
	word_t exp_data [$];

	cpu u_cpu (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.i_mem_out(i_mem_out),
		.d_addr(d_addr),
		.data_mem_in(data_mem_in),
		.data_mem_out(data_mem_out),
		.data_mem_write_enable(data_mem_write_enable),
		.data_mem_read_enable(data_mem_read_enable)
	);

	bind cpu cpu_assertions u_cpu_assertions (
		.clk(clk),
		.reset(reset),
		.d_addr(d_addr),
		.data_mem_write_enable(data_mem_write_enable),
		.data_mem_read_enable(data_mem_read_enable)
	);

	// Both memories answer in the same cycle
	assign i_mem_out = rom[addr[9:2]];
	// Read data is only driven while the read enable is high
	assign data_mem_out = data_mem_read_enable ? dmem[d_addr[9:2]] : 'x;

	always @(posedge clk) begin
		if (data_mem_write_enable)
			dmem[d_addr[9:2]] <= data_mem_in;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

	// Assertion failures end the run at once
	always @(negedge clk) begin
		if (u_cpu.u_cpu_assertions.error_count != 0) begin
			$display("Assertion check failed inside the DUT");
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input word_t instr);
		rom[prog_len] = instr;
		prog_len++;
	endtask

	// Opcodes 0010011 op-imm, 0000011 load, 1100111 jalr, 0110111 lui, 0010111 auipc
	task automatic load_program();
		prog_len = 0;
		emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
		emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, 7'b0010011));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
		emit(enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));
		emit(enc_r(7'h00, 5'd4, 5'd5, 3'b001, 5'd6));
		emit(enc_i(12'h401, 5'd2, 3'b101, 5'd7, 7'b0010011));
		emit(enc_r(7'h00, 5'd4, 5'd7, 3'b101, 5'd8));
		emit(enc_r(7'h00, 5'd6, 5'd7, 3'b010, 5'd9));
		emit(enc_r(7'h00, 5'd6, 5'd7, 3'b011, 5'd10));
		emit(enc_r(7'h00, 5'd6, 5'd9, 3'b110, 5'd11));
		emit(enc_i(12'h0f3, 5'd8, 3'b111, 5'd12, 7'b0010011));
		emit(enc_s(12'h224, 5'd12, 5'd0));
		for (int r = 3; r <= 11; r++)
			emit(enc_s(12'(32'h200 + 4 * (r - 3)), 5'(r), 5'd0));
		// Load then use right away
		emit(enc_i(12'h040, 5'd0, 3'b010, 5'd14, 7'b0000011));
		emit(enc_r(7'h00, 5'd1, 5'd14, 3'b000, 5'd15));
		emit(enc_s(12'h228, 5'd15, 5'd0));
		// blt taken at 0x64 skips two stores
		emit(enc_b(13'd12, 5'd1, 5'd2, 3'b100));
		emit(enc_s(12'h300, 5'd1, 5'd0));
		emit(enc_s(12'h304, 5'd2, 5'd0));
		emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
		emit(enc_s(12'h22c, 5'd1, 5'd0));
		// jal at 0x78
		emit(enc_j(21'd12, 5'd16));
		emit(enc_s(12'h308, 5'd1, 5'd0));
		emit(enc_s(12'h30c, 5'd1, 5'd0));
		emit(enc_s(12'h230, 5'd16, 5'd0));
		emit(enc_i(12'h09c, 5'd0, 3'b000, 5'd17, 7'b0010011));
		// jalr at 0x8c, odd target gets bit 0 cleared
		emit(enc_i(12'h001, 5'd17, 3'b000, 5'd18, 7'b1100111));
		emit(enc_s(12'h310, 5'd1, 5'd0));
		emit(enc_s(12'h314, 5'd1, 5'd0));
		emit(enc_s(12'h318, 5'd1, 5'd0));
		emit(enc_s(12'h234, 5'd18, 5'd0));
		emit(enc_u(20'h12345, 5'd19, 7'b0110111));
		// auipc at 0xa4
		emit(enc_u(20'h00010, 5'd20, 7'b0010111));
		emit(enc_s(12'h238, 5'd19, 5'd0));
		emit(enc_s(12'h23c, 5'd20, 5'd0));
		emit(enc_j(21'd0, 5'd0));
	endtask

	task automatic expect_store(input word_t a, input word_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic build_expected();
		// andi of 0x07ffffff
		expect_store(32'h224, 32'h0000_00f3);
		expect_store(32'h200, 32'd2);
		expect_store(32'h204, 32'd5);
		expect_store(32'h208, 32'd7);
		expect_store(32'h20c, 32'd7 << 5);
		expect_store(32'h210, 32'hffff_fffe);
		expect_store(32'h214, 32'hffff_fffe >> 5);
		expect_store(32'h218, 32'd1);
		expect_store(32'h21c, 32'd0);
		expect_store(32'h220, 32'h0000_00e1);
		expect_store(32'h228, dmem_init[16] + 32'd5);
		expect_store(32'h22c, 32'd5);
		expect_store(32'h230, 32'h78 + 32'd4);
		expect_store(32'h234, 32'h8c + 32'd4);
		expect_store(32'h238, 32'h1234_5000);
		expect_store(32'h23c, 32'h0001_0000 + 32'ha4);
	endtask

	task automatic check_store_addr(input int idx, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: store %0d address %h, expected %h", $time, idx, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic check_store_data(input int idx, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: store %0d data %h, expected %h", $time, idx, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic wait_store(input int idx);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (data_mem_write_enable !== 1'b1) begin
			if (cycles == store_timeout) begin
				$display("Timeout: store %0d to address %h never appeared", idx, exp_addr[idx]);
				$display("*** FAILED ***");
				$fatal(1);
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	initial begin
		seed = 32'heb89;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = $random(seed);
			dmem_init[i] = dmem[i];
			rom[i] = NOP_INSTR;
		end
		load_program();
		build_expected();
		// Watching starts at time zero so a store in reset is caught
		for (int i = 0; i < exp_addr.size(); i++) begin
			wait_store(i);
			check_store_addr(i, d_addr, exp_addr[i]);
			check_store_data(i, data_mem_in, exp_data[i]);
		end
		// Final self-loop must stay quiet
		repeat (20) begin
			@(negedge clk);
			if (data_mem_write_enable !== 1'b0) begin
				$display("ERROR %0t: extra store to address %h", $time, d_addr);
				$display("*** FAILED ***");
				$fatal(1);
			end
		end
		if (u_cpu.u_cpu_assertions.error_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("Assertion checks failed %0d times", u_cpu.u_cpu_assertions.error_count);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
